//--- verilog/rv_defs.svh
`ifndef RV_DEFS_SVH
`define RV_DEFS_SVH

// width of register data and of byte addresses.
`define XLEN 32

// rs2 field width, which is also the shift amount range.
`define SHAMT_WIDTH 5

// entries per FIFO. 2, 4 and 8 are all legal.
`define BUF_DEPTH 2

`endif

//--- verilog/rv_pkg.sv
`default_nettype none

`include "rv_defs.svh"

package rv_pkg;

  typedef logic [`XLEN-1:0] data_t;
  typedef logic [`XLEN-1:0] vaddr_t;

  typedef enum logic [6:0] {
    R         = 7'b0110011,
    IMMEDIATE = 7'b0010011,
    LOAD      = 7'b0000011,
    STORE     = 7'b0100011,
    BRANCH    = 7'b1100011,
    JAL       = 7'b1101111,
    LUI       = 7'b0110111,
    AUIPC     = 7'b0010111,
    SYSTEM    = 7'b1110011
  } opcode_e;

  typedef enum logic {
    BYTE = 1'b0,
    WORD = 1'b1
  } access_size_e;

  typedef struct packed {
    logic [6:0]              funct7;
    logic [`SHAMT_WIDTH-1:0] rs2;
    logic [4:0]              rs1;
    logic [2:0]              funct3;
    logic [4:0]              rd;
    opcode_e                 opcode;
  } instruction_t;

  typedef struct packed {
    instruction_t            instr;
    vaddr_t                  pc;
    data_t                   rs1_data;
    data_t                   rs2_data;
    data_t                   imm;    // sign-extended, already shifted for U-type.
    logic [`SHAMT_WIDTH-1:0] shamt;
  } decoded_t;

  typedef struct packed {
    vaddr_t       pc;
    data_t        result;
    data_t        store_data;
    vaddr_t       target;
    logic [4:0]   rd;
    logic         wr_en;
    logic         is_load;
    logic         is_store;
    logic         branch_taken;
    logic         is_jump;
    access_size_e access_size;
  } exec_result_t;

endpackage : rv_pkg

`default_nettype wire

//--- verilog/alu.sv
`timescale 1ns/1ps
`default_nettype none

`include "rv_defs.svh"

module alu (
  input  rv_pkg::opcode_e opcode_i,
  input  logic [2:0]      funct3_i,
  input  logic [6:0]      funct7_i,
  input  rv_pkg::data_t   a_i,
  input  rv_pkg::data_t   b_i,
  output rv_pkg::data_t   result_o,
  output logic            is_zero_o,
  output logic            is_less_o
);

  import rv_pkg::*;

  logic [`SHAMT_WIDTH-1:0] shift;
  logic                    alt;
  data_t                   diff;

  assign shift = b_i[`SHAMT_WIDTH-1:0];
  assign alt   = funct7_i[5];
  assign diff  = a_i - b_i;

  always_comb begin
    result_o = a_i + b_i;
    if (opcode_i == R || opcode_i == IMMEDIATE) begin
      case (funct3_i)
        3'b000: result_o = (opcode_i == R && alt) ? diff : a_i + b_i; // addi never subtracts.
        3'b001: result_o = a_i << shift;
        3'b010: result_o = data_t'($signed(a_i) < $signed(b_i));
        3'b011: result_o = data_t'(a_i < b_i);
        3'b100: result_o = a_i ^ b_i;
        3'b101: result_o = alt ? data_t'($signed(a_i) >>> shift) : a_i >> shift;
        3'b110: result_o = a_i | b_i;
        default: result_o = a_i & b_i;
      endcase
    end
  end

  assign is_zero_o = (diff == '0);
  assign is_less_o = $signed(a_i) < $signed(b_i);

endmodule : alu

`default_nettype wire

//--- verilog/decode_stage.sv
`timescale 1ns/1ps
`default_nettype none

module decode_stage (
  input  logic                 clk_i,
  input  logic                 arst_n_i,
  input  logic                 instr_valid_i,
  input  rv_pkg::instruction_t instr_i,
  input  rv_pkg::vaddr_t       pc_i,
  input  rv_pkg::data_t        rs1_data_i,
  input  rv_pkg::data_t        rs2_data_i,
  input  logic                 out_ready_i,
  output logic                 instr_ready_o,
  output logic                 out_valid_o,
  output rv_pkg::decoded_t     out_o
);

  import rv_pkg::*;

  logic        valid_q;
  logic        load;
  logic [31:0] raw;
  data_t       imm;
  decoded_t    dec_d;

  assign raw = instr_i;

  always_comb begin
    case (instr_i.opcode)
      IMMEDIATE, LOAD, SYSTEM: imm = {{20{raw[31]}}, raw[31:20]};
      STORE:                   imm = {{20{raw[31]}}, raw[31:25], raw[11:7]};
      BRANCH:                  imm = {{19{raw[31]}}, raw[31], raw[7], raw[30:25],
                                      raw[11:8], 1'b0};
      JAL:                     imm = {{11{raw[31]}}, raw[31], raw[19:12], raw[20],
                                      raw[30:21], 1'b0};
      LUI, AUIPC:              imm = {raw[31:12], 12'b0};
      default:                 imm = '0; // R-type has no immediate.
    endcase
  end

  always_comb begin
    dec_d.instr    = instr_i;
    dec_d.pc       = pc_i;
    dec_d.rs1_data = rs1_data_i;
    dec_d.rs2_data = rs2_data_i;
    dec_d.imm      = imm;
    dec_d.shamt    = instr_i.rs2;
  end

  // the single entry can refill in the same cycle it drains.
  assign instr_ready_o = ~valid_q | out_ready_i;
  assign load          = instr_valid_i & instr_ready_o;
  assign out_valid_o   = valid_q;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      valid_q <= 1'b0;
    end else if (load) begin
      valid_q <= 1'b1;
    end else if (out_ready_i) begin
      valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (load) begin
      out_o <= dec_d;
    end
  end

endmodule : decode_stage

`default_nettype wire

//--- verilog/pipe_fifo.sv
`timescale 1ns/1ps
`default_nettype none

`include "rv_defs.svh"

module pipe_fifo #(
  parameter type payload_t = logic [31:0],
  parameter int  DEPTH     = `BUF_DEPTH
)(
  input  logic     clk_i,
  input  logic     arst_n_i,
  input  logic     wr_valid_i,
  input  payload_t wr_data_i,
  input  logic     rd_ready_i,
  output logic     wr_ready_o,
  output logic     rd_valid_o,
  output payload_t rd_data_o
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  payload_t         mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic             push;
  logic             pop;

  assign wr_ready_o = (count != CNT_W'(DEPTH));
  assign rd_valid_o = (count != '0);
  assign rd_data_o  = mem[rd_ptr]; // head is visible without a read strobe.

  assign push = wr_valid_i & wr_ready_o;
  assign pop  = rd_valid_o & rd_ready_i;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      count <= count + CNT_W'(push) - CNT_W'(pop);
    end
  end

  always_ff @(posedge clk_i) begin
    if (push) begin
      mem[wr_ptr] <= wr_data_i;
    end
  end

endmodule : pipe_fifo

`default_nettype wire

//--- verilog/alu_stage.sv
`timescale 1ns/1ps
`default_nettype none

module alu_stage (
  input  logic                 in_valid_i,
  input  rv_pkg::decoded_t     in_i,
  input  logic                 mem_stall_i,
  output logic                 in_ready_o,
  output logic                 out_valid_o,
  output rv_pkg::exec_result_t out_o
);

  import rv_pkg::*;

  data_t alu_a;
  data_t alu_b;
  data_t alu_result;
  logic  is_zero;
  logic  is_less;

  always_comb begin
    alu_a              = in_i.rs1_data;
    alu_b              = in_i.rs2_data;
    out_o.pc           = in_i.pc;
    out_o.result       = alu_result;
    out_o.store_data   = in_i.rs2_data;
    out_o.target       = in_i.pc + in_i.imm; // shared by branches and jal.
    out_o.rd           = in_i.instr.rd;
    out_o.access_size  = (in_i.instr.funct3 == 3'b000) ? BYTE : WORD;
    out_o.wr_en        = 1'b0;
    out_o.is_load      = 1'b0;
    out_o.is_store     = 1'b0;
    out_o.branch_taken = 1'b0;
    out_o.is_jump      = 1'b0;

    case (in_i.instr.opcode)
      R: begin
        out_o.wr_en = 1'b1;
      end
      IMMEDIATE: begin
        out_o.wr_en = 1'b1;
        case (in_i.instr.funct3)
          3'b001, 3'b101: alu_b = data_t'(in_i.shamt); // slli, srli, srai.
          default:        alu_b = in_i.imm;
        endcase
      end
      LOAD: begin
        out_o.wr_en   = 1'b1;
        out_o.is_load = 1'b1;
        alu_b         = in_i.imm;
      end
      STORE: begin
        out_o.is_store = 1'b1;
        alu_b          = in_i.imm;
      end
      BRANCH: begin
        case (in_i.instr.funct3)
          3'b000:  out_o.branch_taken = is_zero;  // beq.
          3'b001:  out_o.branch_taken = ~is_zero; // bne.
          3'b100:  out_o.branch_taken = is_less;  // blt.
          3'b101:  out_o.branch_taken = ~is_less; // bge.
          default: out_o.branch_taken = 1'b0;
        endcase
      end
      JAL: begin
        out_o.wr_en   = 1'b1;
        out_o.is_jump = 1'b1;
        alu_a         = in_i.pc; // link address is pc plus 4.
        alu_b         = data_t'(4);
      end
      LUI: begin
        out_o.wr_en = 1'b1;
        alu_a       = '0;
        alu_b       = in_i.imm;
      end
      AUIPC: begin
        out_o.wr_en = 1'b1;
        alu_a       = in_i.pc;
        alu_b       = in_i.imm;
      end
      SYSTEM: begin
        out_o.wr_en = 1'b1;
        alu_b       = in_i.imm;
      end
      default: ;
    endcase
  end

  alu u_alu (
    .opcode_i  (in_i.instr.opcode),
    .funct3_i  (in_i.instr.funct3),
    .funct7_i  (in_i.instr.funct7),
    .a_i       (alu_a),
    .b_i       (alu_b),
    .result_o  (alu_result),
    .is_zero_o (is_zero),
    .is_less_o (is_less)
  );

  assign in_ready_o  = ~mem_stall_i;
  assign out_valid_o = in_valid_i;

endmodule : alu_stage

`default_nettype wire

//--- verilog/exec_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "rv_defs.svh"

module exec_top (
  input  logic              clk_i,
  input  logic              arst_n_i,
  input  logic              instr_valid_i,
  input  logic [31:0]       instr_i,
  input  logic [`XLEN-1:0]  pc_i,
  input  logic [`XLEN-1:0]  rs1_data_i,
  input  logic [`XLEN-1:0]  rs2_data_i,
  input  logic              res_ready_i,
  output logic              instr_ready_o,
  output logic              res_valid_o,
  output logic [`XLEN-1:0]  res_pc_o,
  output logic [`XLEN-1:0]  res_data_o,
  output logic [`XLEN-1:0]  res_store_data_o,
  output logic [`XLEN-1:0]  res_target_o,
  output logic [4:0]        res_rd_o,
  output logic              res_wr_en_o,
  output logic              res_is_load_o,
  output logic              res_is_store_o,
  output logic              res_branch_taken_o,
  output logic              res_is_jump_o,
  output logic              res_access_byte_o
);

  import rv_pkg::*;

  instruction_t instr;
  logic         dec_valid, dec_ready;
  decoded_t     dec_data;
  logic         alu_in_valid, alu_in_ready;
  decoded_t     alu_in_data;
  logic         alu_out_valid, res_fifo_ready;
  exec_result_t alu_out_data;
  exec_result_t res;

  assign instr = instr_i;

  decode_stage u_decode (
    .clk_i         (clk_i),
    .arst_n_i      (arst_n_i),
    .instr_valid_i (instr_valid_i),
    .instr_i       (instr),
    .pc_i          (pc_i),
    .rs1_data_i    (rs1_data_i),
    .rs2_data_i    (rs2_data_i),
    .out_ready_i   (dec_ready),
    .instr_ready_o (instr_ready_o),
    .out_valid_o   (dec_valid),
    .out_o         (dec_data)
  );

  pipe_fifo #(.payload_t(decoded_t), .DEPTH(`BUF_DEPTH)) u_dec_fifo (
    .clk_i      (clk_i),
    .arst_n_i   (arst_n_i),
    .wr_valid_i (dec_valid),
    .wr_data_i  (dec_data),
    .rd_ready_i (alu_in_ready),
    .wr_ready_o (dec_ready),
    .rd_valid_o (alu_in_valid),
    .rd_data_o  (alu_in_data)
  );

  // a full result FIFO stalls execute.
  alu_stage u_alu_stage (
    .in_valid_i  (alu_in_valid),
    .in_i        (alu_in_data),
    .mem_stall_i (~res_fifo_ready),
    .in_ready_o  (alu_in_ready),
    .out_valid_o (alu_out_valid),
    .out_o       (alu_out_data)
  );

  pipe_fifo #(.payload_t(exec_result_t), .DEPTH(`BUF_DEPTH)) u_res_fifo (
    .clk_i      (clk_i),
    .arst_n_i   (arst_n_i),
    .wr_valid_i (alu_out_valid),
    .wr_data_i  (alu_out_data),
    .rd_ready_i (res_ready_i),
    .wr_ready_o (res_fifo_ready),
    .rd_valid_o (res_valid_o),
    .rd_data_o  (res)
  );

  assign res_pc_o           = res.pc;
  assign res_data_o         = res.result;
  assign res_store_data_o   = res.store_data;
  assign res_target_o       = res.target;
  assign res_rd_o           = res.rd;
  assign res_wr_en_o        = res.wr_en;
  assign res_is_load_o      = res.is_load;
  assign res_is_store_o     = res.is_store;
  assign res_branch_taken_o = res.branch_taken;
  assign res_is_jump_o      = res.is_jump;
  assign res_access_byte_o  = (res.access_size == BYTE);

endmodule : exec_top

`default_nettype wire

//--- dv/exec_props.sv
`timescale 1ns/1ps
`default_nettype none

module exec_props (
  input logic        clk_i,
  input logic        arst_n_i,
  input logic        res_valid_i,
  input logic        res_ready_i,
  input logic        instr_ready_i,
  input logic [31:0] res_pc_i,
  input logic [31:0] res_data_i,
  input logic [31:0] res_target_i
);

  int failures = 0;

  // a stalled result must wait unchanged.
  property result_held;
    @(posedge clk_i) disable iff (!arst_n_i)
      res_valid_i && !res_ready_i |=> res_valid_i && $stable(res_pc_i)
        && $stable(res_data_i) && $stable(res_target_i);
  endproperty

  assert property (result_held)
    else begin
      $error("result valid dropped or data changed before it was taken");
      failures++;
    end

  assert property (@(posedge clk_i) !arst_n_i |-> !res_valid_i)
    else begin
      $error("result valid is high during reset");
      failures++;
    end

  assert property (@(posedge clk_i) $rose(arst_n_i) |-> instr_ready_i)
    else begin
      $error("instruction ready is low in the first cycle after reset");
      failures++;
    end

endmodule : exec_props

bind exec_top exec_props u_props (
  .clk_i         (clk_i),
  .arst_n_i      (arst_n_i),
  .res_valid_i   (res_valid_o),
  .res_ready_i   (res_ready_i),
  .instr_ready_i (instr_ready_o),
  .res_pc_i      (res_pc_o),
  .res_data_i    (res_data_o),
  .res_target_i  (res_target_o)
);

`default_nettype wire

//--- dv/exec_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "rv_defs.svh"

module exec_tb;

  import rv_pkg::*;

  localparam int N_ARITH     = 40;
  localparam int N_UPPER     = 24;
  localparam int N_BRANCH    = 40;
  localparam int N_MEM       = 32;
  localparam int N_STALL     = 30;
  localparam int TOTAL       = N_ARITH + N_UPPER + N_BRANCH + N_MEM + N_STALL;
  localparam int CYCLE_LIMIT = 20 * TOTAL + 100;

  logic              clk_i;
  logic              arst_n_i;
  logic              instr_valid_i;
  logic [31:0]       instr_i;
  logic [`XLEN-1:0]  pc_i;
  logic [`XLEN-1:0]  rs1_data_i;
  logic [`XLEN-1:0]  rs2_data_i;
  logic              res_ready_i;
  logic              instr_ready_o;
  logic              res_valid_o;
  logic [`XLEN-1:0]  res_pc_o;
  logic [`XLEN-1:0]  res_data_o;
  logic [`XLEN-1:0]  res_store_data_o;
  logic [`XLEN-1:0]  res_target_o;
  logic [4:0]        res_rd_o;
  logic              res_wr_en_o;
  logic              res_is_load_o;
  logic              res_is_store_o;
  logic              res_branch_taken_o;
  logic              res_is_jump_o;
  logic              res_access_byte_o;

  integer       seed = 13861;
  int           cycles = 0;
  int           errors = 0;
  int           tests_passed = 0;
  int           tests_failed = 0;
  int           hold_left = 0;
  int           received = 0;
  logic         stall_test = 1'b0;
  logic         stall_seen = 1'b0;
  exec_result_t expected_q[$];

  exec_top DUT (
    .clk_i              (clk_i),
    .arst_n_i           (arst_n_i),
    .instr_valid_i      (instr_valid_i),
    .instr_i            (instr_i),
    .pc_i               (pc_i),
    .rs1_data_i         (rs1_data_i),
    .rs2_data_i         (rs2_data_i),
    .res_ready_i        (res_ready_i),
    .instr_ready_o      (instr_ready_o),
    .res_valid_o        (res_valid_o),
    .res_pc_o           (res_pc_o),
    .res_data_o         (res_data_o),
    .res_store_data_o   (res_store_data_o),
    .res_target_o       (res_target_o),
    .res_rd_o           (res_rd_o),
    .res_wr_en_o        (res_wr_en_o),
    .res_is_load_o      (res_is_load_o),
    .res_is_store_o     (res_is_store_o),
    .res_branch_taken_o (res_branch_taken_o),
    .res_is_jump_o      (res_is_jump_o),
    .res_access_byte_o  (res_access_byte_o)
  );

  always #2 clk_i = ~clk_i;

  always @(posedge clk_i) begin
    cycles++;
    if (cycles > CYCLE_LIMIT) begin
      $display("timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
      $display("STATUS: FAIL");
      $finish;
    end
  end

  function automatic logic [6:0] opcode_of(int kind);
    case (kind)
      0:       return R;
      1:       return IMMEDIATE;
      2:       return LOAD;
      3:       return STORE;
      4:       return BRANCH;
      5:       return JAL;
      6:       return LUI;
      7:       return AUIPC;
      default: return SYSTEM;
    endcase
  endfunction

  function automatic logic [31:0] imm_of(logic [31:0] w);
    case (w[6:0])
      IMMEDIATE, LOAD, SYSTEM: return $signed(w) >>> 20;
      STORE:      return ((32'($signed(w) >>> 20)) & ~32'h1f) | {27'b0, w[11:7]};
      BRANCH:     return {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
      JAL:        return {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
      LUI, AUIPC: return w & 32'hffff_f000;
      default:    return 32'h0; // R-type carries no immediate.
    endcase
  endfunction

  function automatic logic [31:0] alu_op(logic [2:0] f3, logic alt, logic [31:0] a,
                                         logic [31:0] b);
    case (f3)
      3'd0:    return alt ? a - b : a + b;
      3'd1:    return a << b[4:0];
      3'd2:    return $signed(a) < $signed(b);
      3'd3:    return a < b;
      3'd4:    return a ^ b;
      3'd5: begin
        if (alt) return $signed(a) >>> b[4:0];
        else return a >> b[4:0];
      end
      3'd6:    return a | b;
      default: return a & b;
    endcase
  endfunction

  function automatic exec_result_t expected_result(logic [31:0] w, logic [31:0] pc,
                                                   logic [31:0] rs1, logic [31:0] rs2);
    exec_result_t r;
    logic [31:0]  imm;
    logic [2:0]   f3;
    logic         is_shift;
    imm           = imm_of(w);
    f3            = w[14:12];
    is_shift      = (f3 == 3'b001) || (f3 == 3'b101);
    r             = '0;
    r.pc          = pc;
    r.store_data  = rs2;
    r.target      = pc + imm;
    r.rd          = w[11:7];
    r.access_size = (f3 == 3'b000) ? BYTE : WORD;
    r.wr_en       = 1'b1;
    case (w[6:0])
      R:         r.result = alu_op(f3, w[30], rs1, rs2);
      IMMEDIATE: r.result = alu_op(f3, (f3 == 3'b101) & w[30], rs1,
                                   is_shift ? {27'b0, w[24:20]} : imm);
      LOAD: begin
        r.result  = rs1 + imm;
        r.is_load = 1'b1;
      end
      STORE: begin
        r.result   = rs1 + imm;
        r.is_store = 1'b1;
        r.wr_en    = 1'b0;
      end
      BRANCH: begin
        r.result = rs1 + rs2;
        r.wr_en  = 1'b0;
        case (f3)
          3'b000:  r.branch_taken = (rs1 == rs2);
          3'b001:  r.branch_taken = (rs1 != rs2);
          3'b100:  r.branch_taken = $signed(rs1) < $signed(rs2);
          3'b101:  r.branch_taken = $signed(rs1) >= $signed(rs2);
          default: r.branch_taken = 1'b0;
        endcase
      end
      JAL: begin
        r.result  = pc + 32'd4;
        r.is_jump = 1'b1;
      end
      LUI:     r.result = imm;
      AUIPC:   r.result = pc + imm;
      default: r.result = rs1 + imm; // system.
    endcase
    return r;
  endfunction

  task automatic gen_instr(input int kind, output logic [31:0] w);
    logic [2:0] f3;
    w  = $random(seed);
    f3 = w[14:12];
    case (kind)
      0: w[31:25] = {1'b0, w[30], 5'b0};
      1: if (f3 == 3'b001 || f3 == 3'b101) w[31:25] = {1'b0, (f3 == 3'b101) & w[30], 5'b0};
      2, 3: f3 = {1'b0, w[13], 1'b0}; // byte or word access.
      4: f3 = {w[13], 1'b0, w[12]};
      8: f3 = 3'b000;
      default: ;
    endcase
    w[14:12] = f3;
    w[6:0]   = opcode_of(kind);
  endtask

  task automatic step_cycle();
    @(negedge clk_i);
    if (hold_left > 0) begin
      res_ready_i = 1'b0;
      hold_left--;
    end else if (stall_test) begin
      res_ready_i = 1'b1;
    end else begin
      res_ready_i = ($unsigned($random(seed)) % 10) < 7;
    end
  endtask

  task automatic send(input logic [31:0] w, input logic [31:0] pc, input logic [31:0] a,
                      input logic [31:0] b);
    instr_valid_i = 1'b1;
    instr_i       = w;
    pc_i          = pc;
    rs1_data_i    = a;
    rs2_data_i    = b;
    #1;
    while (!instr_ready_o) begin
      stall_seen = 1'b1;
      step_cycle();
      #1;
    end
    expected_q.push_back(expected_result(w, pc, a, b));
    step_cycle(); // the transfer happens on the rising edge in between.
    instr_valid_i = 1'b0;
  endtask

  task automatic drain();
    while (expected_q.size() != 0) step_cycle();
    repeat (4) step_cycle(); // room for a stray extra result to show up.
  endtask

  task automatic compare(input string name, input logic [31:0] exp, input logic [31:0] act);
    assert (act === exp) else begin
      $display("[ERROR] %s expected %h got %h", name, exp, act);
      errors++;
    end
  endtask

  task automatic check_result();
    exec_result_t e;
    assert (expected_q.size() != 0) else begin
      $display("a result for pc %h came out with no instruction pending", res_pc_o);
      errors++;
    end
    if (expected_q.size() != 0) begin
      e = expected_q.pop_front();
      compare("res_pc_o", e.pc, res_pc_o);
      compare("res_data_o", e.result, res_data_o);
      compare("res_store_data_o", e.store_data, res_store_data_o);
      compare("res_target_o", e.target, res_target_o);
      compare("res_rd_o", e.rd, res_rd_o);
      compare("res_wr_en_o", e.wr_en, res_wr_en_o);
      compare("res_is_load_o", e.is_load, res_is_load_o);
      compare("res_is_store_o", e.is_store, res_is_store_o);
      compare("res_branch_taken_o", e.branch_taken, res_branch_taken_o);
      compare("res_is_jump_o", e.is_jump, res_is_jump_o);
      compare("res_access_byte_o", e.access_size == BYTE, res_access_byte_o);
    end
    received++;
  endtask

  // outputs are sampled a quarter period ahead of the rising edge.
  always begin
    @(negedge clk_i);
    #1;
    if (arst_n_i && res_valid_o && res_ready_i) check_result();
  end

  task automatic finish_test(input string name, input int first_err);
    if (errors == first_err) begin
      tests_passed++;
      $display("test %s: ok", name);
    end else begin
      tests_failed++;
      $display("test %s: %0d errors", name, errors - first_err);
    end
  endtask

  initial begin
    logic [31:0] w;
    logic [31:0] a;
    int          first;
    clk_i         = 1'b0;
    arst_n_i      = 1'b0;
    instr_valid_i = 1'b0;
    instr_i       = '0;
    pc_i          = '0;
    rs1_data_i    = '0;
    rs2_data_i    = '0;
    res_ready_i   = 1'b0;
    repeat (2) @(posedge clk_i);
    @(negedge clk_i);
    arst_n_i = 1'b1;

    first = errors;
    repeat (N_ARITH) begin
      gen_instr($unsigned($random(seed)) % 2, w);
      send(w, $random(seed), $random(seed), $random(seed));
    end
    drain();
    finish_test("1 arithmetic", first);

    first = errors;
    repeat (N_UPPER) begin
      gen_instr($unsigned($random(seed)) % 3 + 5, w);
      send(w, $random(seed), $random(seed), $random(seed));
    end
    drain();
    finish_test("2 lui/auipc/jal", first);

    first = errors;
    repeat (N_BRANCH) begin
      gen_instr(4, w);
      a = $random(seed);
      if ($random(seed) & 1) send(w, $random(seed), a, a);
      else send(w, $random(seed), a, $random(seed));
    end
    drain();
    finish_test("3 branches", first);

    first = errors;
    repeat (N_MEM) begin
      gen_instr($unsigned($random(seed)) % 2 + 2, w);
      send(w, $random(seed), $random(seed), $random(seed));
    end
    drain();
    finish_test("4 load/store", first);

    // result port held off for 30 cycles, then always ready.
    first       = errors;
    stall_test  = 1'b1;
    stall_seen  = 1'b0;
    received    = 0;
    hold_left   = 30;
    res_ready_i = 1'b0;
    a           = $random(seed) & 32'hffff_fffc;
    for (int i = 0; i < N_STALL; i++) begin
      gen_instr($unsigned($random(seed)) % 9, w);
      send(w, a + 32'(4 * i), $random(seed), $random(seed));
    end
    drain();
    assert (stall_seen) else begin
      $display("instr_ready_o never fell while results were held off");
      errors++;
    end
    assert (received == N_STALL) else begin
      $display("%0d results came out for %0d instructions", received, N_STALL);
      errors++;
    end
    finish_test("5 back-pressure", first);

    assert (DUT.u_props.failures == 0) else begin
      $display("the bound handshake assertions failed %0d times", DUT.u_props.failures);
      errors++;
    end

    $display("tests passed: %0d, tests failed: %0d", tests_passed, tests_failed);
    if (errors == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule : exec_tb

`default_nettype wire

//--- build.f
+incdir+verilog
verilog/rv_pkg.sv
verilog/alu.sv
verilog/decode_stage.sv
verilog/pipe_fifo.sv
verilog/alu_stage.sv
verilog/exec_top.sv
dv/exec_props.sv
dv/exec_tb.sv
